/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_exec_cluster
FILELIST = mips_exec.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* hw/alu.sv */
module alu (
    input  mips_pkg::word_t srca,
    input  mips_pkg::word_t srcb,
    input  mips_pkg::op_t   op,
    output mips_pkg::word_t result,
    output logic            overflow
);

    mips_pkg::word_t sum;
    mips_pkg::word_t diff;
    mips_pkg::word_t lead;
    logic [5:0]      lead_cnt;
    logic            sum_ovf;
    logic            diff_ovf;

    assign sum  = srca + srcb;
    assign diff = srca - srcb;

    // Signed overflow when the operand signs agree and the result sign flips.
    assign sum_ovf  = (srca[31] == srcb[31]) && (sum[31] != srca[31]);
    assign diff_ovf = (srca[31] != srcb[31]) && (diff[31] != srca[31]);

    // CLO counts leading zeros of the inverted operand.
    assign lead = (op == mips_pkg::OP_CLO) ? ~srca : srca;

    always_comb
    begin
        lead_cnt = 6'd32;
        for (int i = 0; i < 32; i++)
        begin
            if (lead[i])
                lead_cnt = 6'(31 - i);   // Highest set bit wins.
        end
    end

    always_comb
    begin
        overflow = 1'b0;
        case (op)
            mips_pkg::OP_ADD:
            begin
                result   = sum;
                overflow = sum_ovf;
            end
            mips_pkg::OP_ADDU: result = sum;
            mips_pkg::OP_SUB:
            begin
                result   = diff;
                overflow = diff_ovf;
            end
            mips_pkg::OP_SUBU: result = diff;
            mips_pkg::OP_AND:  result = srca & srcb;
            mips_pkg::OP_OR:   result = srca | srcb;
            mips_pkg::OP_XOR:  result = srca ^ srcb;
            mips_pkg::OP_NOR:  result = ~(srca | srcb);
            mips_pkg::OP_SLT:  result = {31'b0, $signed(srca) < $signed(srcb)};
            mips_pkg::OP_SLTU: result = {31'b0, srca < srcb};
            mips_pkg::OP_SLL, mips_pkg::OP_SLLV:
                result = srcb << srca[4:0];
            mips_pkg::OP_SRL, mips_pkg::OP_SRLV:
                result = srcb >> srca[4:0];
            mips_pkg::OP_SRA, mips_pkg::OP_SRAV:
                result = $signed(srcb) >>> srca[4:0];
            mips_pkg::OP_LUI:  result = {srcb[15:0], 16'h0000};
            mips_pkg::OP_CLO, mips_pkg::OP_CLZ:
                result = {26'b0, lead_cnt};
            mips_pkg::OP_MOVZ, mips_pkg::OP_MOVN:
                result = srca;                   // Moves rs, write enable decided outside.
            default:           result = '0;
        endcase
    end

endmodule

/* hw/exec_cluster.sv */
module exec_cluster (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  mips_pkg::issue_data_t in0,
    input  mips_pkg::issue_data_t in1,
    output mips_pkg::exec_data_t  out0,
    output mips_pkg::exec_data_t  out1,
    output logic                  finish0,
    output logic                  finish1
);

    mips_pkg::md_req_t  lane_req  [mips_pkg::N_LANES];
    mips_pkg::md_resp_t lane_resp [mips_pkg::N_LANES];
    mips_pkg::md_req_t  unit_req;
    mips_pkg::md_resp_t unit_resp;

    exec_unit u_lane0 (
        .clk     (clk),
        .reset   (reset),
        .in      (in0),
        .out     (out0),
        .finish  (finish0),
        .md_req  (lane_req[0]),
        .md_resp (lane_resp[0])
    );

    exec_unit u_lane1 (
        .clk     (clk),
        .reset   (reset),
        .in      (in1),
        .out     (out1),
        .finish  (finish1),
        .md_req  (lane_req[1]),
        .md_resp (lane_resp[1])
    );

    muldiv_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .lane_req  (lane_req),
        .lane_resp (lane_resp),
        .unit_req  (unit_req),
        .unit_resp (unit_resp)
    );

    muldiv_unit u_muldiv (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .req   (unit_req),
        .resp  (unit_resp)
    );

endmodule

/* hw/exec_unit.sv */
module exec_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  mips_pkg::issue_data_t in,
    output mips_pkg::exec_data_t  out,
    output logic                  finish,
    output mips_pkg::md_req_t     md_req,
    input  mips_pkg::md_resp_t    md_resp
);

    mips_pkg::word_t    alu_a;
    mips_pkg::word_t    alu_b;
    mips_pkg::word_t    alu_result;
    mips_pkg::word_t    link_addr;
    logic               alu_overflow;
    logic               shift_imm;
    logic               is_md;
    logic               taken;
    mips_pkg::md_op_t   md_op;
    mips_pkg::md_resp_t resp_q;
    mips_pkg::md_resp_t md_view;

    ////////////////////////////////////////////////////////////////////////////
    // Operand select and ALU
    ////////////////////////////////////////////////////////////////////////////

    assign shift_imm = (in.op == mips_pkg::OP_SLL) || (in.op == mips_pkg::OP_SRL) ||
                       (in.op == mips_pkg::OP_SRA);

    assign alu_a = shift_imm ? {27'b0, in.shamt} : in.srca;
    assign alu_b = in.use_imm ? in.imm : in.srcb;

    alu u_alu (
        .srca     (alu_a),
        .srcb     (alu_b),
        .op       (in.op),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    assign link_addr = in.pcplus4 + 32'd4;      // PC plus 8.

    // Branch conditions.
    always_comb
    begin
        case (in.op)
            mips_pkg::OP_BEQ:  taken = (in.srca == in.srcb);
            mips_pkg::OP_BNE:  taken = (in.srca != in.srcb);
            mips_pkg::OP_BLEZ: taken = in.srca[31] || (in.srca == '0);
            mips_pkg::OP_BGTZ: taken = !in.srca[31] && (in.srca != '0);
            mips_pkg::OP_BLTZ: taken = in.srca[31];
            mips_pkg::OP_BGEZ: taken = !in.srca[31];
            mips_pkg::OP_JAL:  taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // HI/LO operations go to the shared unit
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        is_md = 1'b1;
        md_op = mips_pkg::MD_MFLO;
        case (in.op)
            mips_pkg::OP_MULT:  md_op = mips_pkg::MD_MULT;
            mips_pkg::OP_MULTU: md_op = mips_pkg::MD_MULTU;
            mips_pkg::OP_DIV:   md_op = mips_pkg::MD_DIV;
            mips_pkg::OP_DIVU:  md_op = mips_pkg::MD_DIVU;
            mips_pkg::OP_MADD:  md_op = mips_pkg::MD_MADD;
            mips_pkg::OP_MADDU: md_op = mips_pkg::MD_MADDU;
            mips_pkg::OP_MSUB:  md_op = mips_pkg::MD_MSUB;
            mips_pkg::OP_MSUBU: md_op = mips_pkg::MD_MSUBU;
            mips_pkg::OP_MFHI:  md_op = mips_pkg::MD_MFHI;
            mips_pkg::OP_MFLO:  md_op = mips_pkg::MD_MFLO;
            default:            is_md = 1'b0;
        endcase
    end

    assign md_req.valid = in.valid && is_md;    // Held until done.
    assign md_req.md_op = md_op;
    assign md_req.srca  = alu_a;
    assign md_req.srcb  = alu_b;

    // Last HI/LO seen by this lane, kept past the done pulse.
    always_ff @(posedge clk)
    begin
        if (reset)
            resp_q <= '0;
        else if (md_resp.done)
            resp_q <= md_resp;
    end

    assign md_view = md_resp.done ? md_resp : resp_q;

    assign finish = !(in.valid && is_md) || md_resp.done;

    ////////////////////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        out.valid    = in.valid && finish;
        out.destreg  = in.destreg;
        out.taken    = taken;
        out.overflow = alu_overflow;
        out.hiresult = is_md ? md_view.hi : alu_result;
        out.loresult = is_md ? md_view.lo : alu_result;

        if (in.op == mips_pkg::OP_JAL)
            out.result = link_addr;
        else if (is_md)
            out.result = (in.op == mips_pkg::OP_MFHI) ? md_view.hi : md_view.lo;
        else
            out.result = alu_result;

        case (in.op)
            mips_pkg::OP_MOVZ: out.regwrite = (in.srcb == '0);
            mips_pkg::OP_MOVN: out.regwrite = (in.srcb != '0);
            mips_pkg::OP_NOP,
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ,
            mips_pkg::OP_BGTZ, mips_pkg::OP_BLTZ, mips_pkg::OP_BGEZ,
            mips_pkg::OP_MULT, mips_pkg::OP_MULTU, mips_pkg::OP_DIV, mips_pkg::OP_DIVU,
            mips_pkg::OP_MADD, mips_pkg::OP_MADDU, mips_pkg::OP_MSUB, mips_pkg::OP_MSUBU:
                out.regwrite = 1'b0;             // Branches and HI/LO writers.
            default:           out.regwrite = 1'b1;
        endcase
    end

endmodule

/* hw/mips_pkg.sv */
package mips_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and latencies
    ////////////////////////////////////////////////////////////////////////////

    localparam int MUL_CYCLES = 3;     // Busy cycles for multiply and accumulate.
    localparam int DIV_CYCLES = 32;    // One quotient bit per cycle.
    localparam int N_LANES    = 2;
    localparam int LANE_BITS  = $clog2(N_LANES);

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes and states
    ////////////////////////////////////////////////////////////////////////////

    // Issued operation, already decoded upstream.
    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_LUI, OP_CLO, OP_CLZ,
        OP_MOVZ, OP_MOVN,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_BGEZ,
        OP_JAL,
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
        OP_MFHI, OP_MFLO
    } op_t;

    typedef enum logic [3:0] {
        MD_MULT, MD_MULTU, MD_DIV, MD_DIVU,
        MD_MADD, MD_MADDU, MD_MSUB, MD_MSUBU,
        MD_MFHI, MD_MFLO
    } md_op_t;

    typedef enum logic [1:0] {
        IDLE,
        MUL_BUSY,
        DIV_BUSY,
        DONE
    } md_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      valid;
        op_t       op;
        word_t     srca;
        word_t     srcb;
        word_t     imm;        // Sign or zero extended upstream.
        logic      use_imm;
        logic [4:0] shamt;
        reg_addr_t destreg;
        word_t     pcplus4;
    } issue_data_t;

    typedef struct packed {
        logic      valid;
        word_t     result;
        word_t     hiresult;
        word_t     loresult;
        logic      taken;
        logic      overflow;
        logic      regwrite;
        reg_addr_t destreg;
    } exec_data_t;

    typedef struct packed {
        logic   valid;
        md_op_t md_op;
        word_t  srca;
        word_t  srcb;
    } md_req_t;

    typedef struct packed {
        logic  done;
        word_t hi;
        word_t lo;
    } md_resp_t;

endpackage

/* hw/muldiv_arbiter.sv */
module muldiv_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  mips_pkg::md_req_t  lane_req  [mips_pkg::N_LANES],
    output mips_pkg::md_resp_t lane_resp [mips_pkg::N_LANES],
    output mips_pkg::md_req_t  unit_req,
    input  mips_pkg::md_resp_t unit_resp
);

    logic [mips_pkg::LANE_BITS-1:0] ptr_q, owner_q, pick, sel;
    logic                           busy_q, any_req;

    // Nearest requester at or after the pointer.
    always_comb
    begin
        int idx;
        pick    = ptr_q;
        any_req = 1'b0;
        for (int k = mips_pkg::N_LANES - 1; k >= 0; k--)
        begin
            idx = (int'(ptr_q) + k) % mips_pkg::N_LANES;
            if (lane_req[idx].valid)
            begin
                pick    = mips_pkg::LANE_BITS'(idx);
                any_req = 1'b1;
            end
        end
    end

    assign sel = busy_q ? owner_q : pick;

    always_comb
    begin
        unit_req = lane_req[sel];
        if (unit_resp.done || flush)
            unit_req.valid = 1'b0;               // Stale request on the done cycle.
        for (int i = 0; i < mips_pkg::N_LANES; i++)
        begin
            lane_resp[i].done = unit_resp.done && busy_q &&
                                (owner_q == mips_pkg::LANE_BITS'(i));
            lane_resp[i].hi   = unit_resp.hi;
            lane_resp[i].lo   = unit_resp.lo;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy_q  <= 1'b0;
            owner_q <= '0;
            ptr_q   <= '0;
        end
        else if (flush)
            busy_q <= 1'b0;
        else if (busy_q && unit_resp.done)
        begin
            busy_q <= 1'b0;
            ptr_q  <= (owner_q == mips_pkg::LANE_BITS'(mips_pkg::N_LANES - 1)) ? '0 :
                      owner_q + 1'b1;
        end
        else if (!busy_q && any_req && !unit_resp.done)
        begin
            busy_q  <= 1'b1;
            owner_q <= pick;
        end
    end

endmodule

/* hw/muldiv_unit.sv */
module muldiv_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  mips_pkg::md_req_t  req,
    output mips_pkg::md_resp_t resp
);

    mips_pkg::md_state_t state;
    mips_pkg::md_op_t    op_q;
    mips_pkg::word_t     a_q, b_q;
    mips_pkg::word_t     hi, lo;
    mips_pkg::word_t     rem_q, quo_q, dvs_q;
    mips_pkg::word_t     rem_nx, quo_nx, hi_div, lo_div;
    logic [5:0]          cnt;
    logic                md_signed;
    logic                q_neg, r_neg;
    logic signed [63:0]  prod_s;
    logic [63:0]         prod, hilo_acc;
    logic [32:0]         rem_sh, diff;

    assign md_signed = (op_q == mips_pkg::MD_MULT) || (op_q == mips_pkg::MD_MADD) ||
                       (op_q == mips_pkg::MD_MSUB);

    assign prod_s = $signed(a_q) * $signed(b_q);
    assign prod   = md_signed ? prod_s : {32'b0, a_q} * {32'b0, b_q};

    always_comb
    begin
        case (op_q)
            mips_pkg::MD_MADD, mips_pkg::MD_MADDU: hilo_acc = {hi, lo} + prod;
            mips_pkg::MD_MSUB, mips_pkg::MD_MSUBU: hilo_acc = {hi, lo} - prod;
            default:                               hilo_acc = prod;
        endcase
    end

    // One restoring step on magnitudes.
    assign rem_sh = {rem_q, quo_q[31]};
    assign diff   = rem_sh - {1'b0, dvs_q};
    assign rem_nx = diff[32] ? rem_sh[31:0] : diff[31:0];
    assign quo_nx = {quo_q[30:0], !diff[32]};

    assign q_neg  = (op_q == mips_pkg::MD_DIV) && (a_q[31] ^ b_q[31]);
    assign r_neg  = (op_q == mips_pkg::MD_DIV) && a_q[31];   // Remainder follows dividend.
    assign hi_div = (b_q == '0) ? a_q : (r_neg ? -rem_nx : rem_nx);
    assign lo_div = (b_q == '0) ? '1 : (q_neg ? -quo_nx : quo_nx);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= mips_pkg::IDLE;
            cnt   <= '0;
            hi    <= '0;
            lo    <= '0;
        end
        else if (flush)
            state <= mips_pkg::IDLE;             // HI and LO stay as they are.
        else
        begin
            case (state)
                mips_pkg::IDLE:
                    if (req.valid)
                    begin
                        case (req.md_op)
                            mips_pkg::MD_MFHI, mips_pkg::MD_MFLO:
                                state <= mips_pkg::DONE;
                            mips_pkg::MD_DIV, mips_pkg::MD_DIVU:
                            begin
                                state <= mips_pkg::DIV_BUSY;
                                cnt   <= 6'(mips_pkg::DIV_CYCLES - 1);
                            end
                            default:
                            begin
                                state <= mips_pkg::MUL_BUSY;
                                cnt   <= 6'(mips_pkg::MUL_CYCLES - 1);
                            end
                        endcase
                    end
                mips_pkg::MUL_BUSY:
                begin
                    cnt <= cnt - 6'd1;
                    if (cnt == '0)
                    begin
                        {hi, lo} <= hilo_acc;
                        state    <= mips_pkg::DONE;
                    end
                end
                mips_pkg::DIV_BUSY:
                begin
                    cnt <= cnt - 6'd1;
                    if (cnt == '0)
                    begin
                        hi    <= hi_div;
                        lo    <= lo_div;
                        state <= mips_pkg::DONE;
                    end
                end
                default: state <= mips_pkg::IDLE;
            endcase
        end
    end

    // Operands and divider working registers.
    always_ff @(posedge clk)
    begin
        if (state == mips_pkg::IDLE && req.valid)
        begin
            op_q  <= req.md_op;
            a_q   <= req.srca;
            b_q   <= req.srcb;
            rem_q <= '0;
            quo_q <= (req.md_op == mips_pkg::MD_DIV && req.srca[31]) ? -req.srca : req.srca;
            dvs_q <= (req.md_op == mips_pkg::MD_DIV && req.srcb[31]) ? -req.srcb : req.srcb;
        end
        else if (state == mips_pkg::DIV_BUSY)
        begin
            rem_q <= rem_nx;
            quo_q <= quo_nx;
        end
    end

    assign resp.done = (state == mips_pkg::DONE);
    assign resp.hi   = hi;
    assign resp.lo   = lo;

endmodule

/* mips_exec.f */
+incdir+test
hw/mips_pkg.sv
hw/alu.sv
hw/exec_unit.sv
hw/muldiv_arbiter.sv
hw/muldiv_unit.sv
hw/exec_cluster.sv
test/tb_exec_cluster.sv

/* test/exec_model.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic logic is_hilo(input mips_pkg::op_t op);
    return op inside {mips_pkg::OP_MULT, mips_pkg::OP_MULTU, mips_pkg::OP_DIV,
                      mips_pkg::OP_DIVU, mips_pkg::OP_MADD, mips_pkg::OP_MADDU,
                      mips_pkg::OP_MSUB, mips_pkg::OP_MSUBU, mips_pkg::OP_MFHI,
                      mips_pkg::OP_MFLO};
endfunction

// Run of bits equal to bit_val, counted down from bit 31.
function automatic mips_pkg::word_t leading_count(input mips_pkg::word_t v, input logic bit_val);
    int n;
    n = 0;
    for (int i = 31; i >= 0 && v[i] == bit_val; i--)
        n++;
    return mips_pkg::word_t'(n);
endfunction

function automatic mips_pkg::word_t alu_expect(input mips_pkg::issue_data_t ins);
    mips_pkg::word_t a;
    mips_pkg::word_t b;
    logic [4:0]      amt;
    a   = ins.srca;
    b   = ins.use_imm ? ins.imm : ins.srcb;
    amt = (ins.op inside {mips_pkg::OP_SLL, mips_pkg::OP_SRL, mips_pkg::OP_SRA}) ?
          ins.shamt : a[4:0];                   // Fixed shifts use shamt.
    case (ins.op)
        mips_pkg::OP_ADD, mips_pkg::OP_ADDU: return a + b;
        mips_pkg::OP_SUB, mips_pkg::OP_SUBU: return a - b;
        mips_pkg::OP_AND:  return a & b;
        mips_pkg::OP_OR:   return a | b;
        mips_pkg::OP_XOR:  return a ^ b;
        mips_pkg::OP_NOR:  return ~(a | b);
        mips_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        mips_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
        mips_pkg::OP_SLL, mips_pkg::OP_SLLV: return b << amt;
        mips_pkg::OP_SRL, mips_pkg::OP_SRLV: return b >> amt;
        mips_pkg::OP_SRA, mips_pkg::OP_SRAV: return mips_pkg::word_t'($signed(b) >>> amt);
        mips_pkg::OP_LUI:  return {b[15:0], 16'h0000};
        mips_pkg::OP_CLO:  return leading_count(a, 1'b1);
        mips_pkg::OP_CLZ:  return leading_count(a, 1'b0);
        mips_pkg::OP_MOVZ, mips_pkg::OP_MOVN: return a;
        mips_pkg::OP_JAL:  return ins.pcplus4 + 32'd4;   // PC plus 8.
        default:           return '0;
    endcase
endfunction

// A signed result overflows when it does not survive a trip through 32 bits.
function automatic logic overflow_expect(input mips_pkg::issue_data_t ins);
    longint a;
    longint b;
    longint r;
    a = longint'($signed(ins.srca));
    b = longint'($signed(ins.use_imm ? ins.imm : ins.srcb));
    case (ins.op)
        mips_pkg::OP_ADD: r = a + b;
        mips_pkg::OP_SUB: r = a - b;
        default:          r = 0;
    endcase
    return r != longint'($signed(r[31:0]));
endfunction

function automatic logic taken_expect(input mips_pkg::issue_data_t ins);
    logic neg;
    logic zero;
    neg  = ins.srca[31];
    zero = (ins.srca == 32'd0);
    case (ins.op)
        mips_pkg::OP_BEQ:  return ins.srca == ins.srcb;
        mips_pkg::OP_BNE:  return ins.srca != ins.srcb;
        mips_pkg::OP_BLEZ: return neg || zero;
        mips_pkg::OP_BGTZ: return !neg && !zero;
        mips_pkg::OP_BLTZ: return neg;
        mips_pkg::OP_BGEZ: return !neg;
        mips_pkg::OP_JAL:  return 1'b1;
        default:           return 1'b0;
    endcase
endfunction

function automatic logic regwrite_expect(input mips_pkg::issue_data_t ins);
    case (ins.op)
        mips_pkg::OP_MOVZ: return ins.srcb == 32'd0;
        mips_pkg::OP_MOVN: return ins.srcb != 32'd0;
        mips_pkg::OP_MFHI, mips_pkg::OP_MFLO: return 1'b1;
        mips_pkg::OP_NOP, mips_pkg::OP_BEQ, mips_pkg::OP_BNE, mips_pkg::OP_BLEZ,
        mips_pkg::OP_BGTZ, mips_pkg::OP_BLTZ, mips_pkg::OP_BGEZ: return 1'b0;
        default:           return !is_hilo(ins.op);
    endcase
endfunction

task automatic apply_hilo(input mips_pkg::op_t op, input mips_pkg::word_t a,
                          input mips_pkg::word_t b, inout mips_pkg::word_t hi,
                          inout mips_pkg::word_t lo);
    logic [63:0] sprod;
    logic [63:0] uprod;
    longint      q;
    longint      r;
    sprod = 64'(longint'($signed(a)) * longint'($signed(b)));
    uprod = {32'b0, a} * {32'b0, b};
    q     = 0;
    r     = 0;
    if (b != 32'd0)
    begin
        q = longint'($signed(a)) / longint'($signed(b));   // Truncates toward zero.
        r = longint'($signed(a)) % longint'($signed(b));
    end
    case (op)
        mips_pkg::OP_MULT:  {hi, lo} = sprod;
        mips_pkg::OP_MULTU: {hi, lo} = uprod;
        mips_pkg::OP_MADD:  {hi, lo} = {hi, lo} + sprod;
        mips_pkg::OP_MADDU: {hi, lo} = {hi, lo} + uprod;
        mips_pkg::OP_MSUB:  {hi, lo} = {hi, lo} - sprod;
        mips_pkg::OP_MSUBU: {hi, lo} = {hi, lo} - uprod;
        mips_pkg::OP_DIV:   {hi, lo} = (b == 32'd0) ? {a, 32'hffff_ffff} : {r[31:0], q[31:0]};
        mips_pkg::OP_DIVU:  {hi, lo} = (b == 32'd0) ? {a, 32'hffff_ffff} : {a % b, a / b};
        default: ;                                  // MFHI and MFLO only read.
    endcase
endtask

`endif

/* test/tb_exec_cluster.sv */
module tb_exec_cluster;

    localparam int TIMEOUT_CYCLES = 100;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    mips_pkg::issue_data_t in0;
    mips_pkg::issue_data_t in1;
    mips_pkg::exec_data_t  out0;
    mips_pkg::exec_data_t  out1;
    logic                  finish0;
    logic                  finish1;

    integer          seed;
    mips_pkg::word_t model_hi;
    mips_pkg::word_t model_lo;

    `include "exec_model.svh"

    exec_cluster UUT (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .in0     (in0),
        .in1     (in1),
        .out0    (out0),
        .out1    (out1),
        .finish0 (finish0),
        .finish1 (finish1)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            abort_run($sformatf("error at %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
    endtask

    task automatic check_result(input int lane, input mips_pkg::issue_data_t ins,
                                input mips_pkg::exec_data_t res);
        string p;
        p = $sformatf("out%0d.", lane);
        check_value({p, "valid"}, res.valid, 1'b1);
        check_value({p, "destreg"}, res.destreg, ins.destreg);
        check_value({p, "taken"}, res.taken, taken_expect(ins));
        check_value({p, "overflow"}, res.overflow, overflow_expect(ins));
        check_value({p, "regwrite"}, res.regwrite, regwrite_expect(ins));
        if (is_hilo(ins.op))
        begin
            apply_hilo(ins.op, ins.srca, ins.srcb, model_hi, model_lo);   // Finish order.
            check_value({p, "hiresult"}, res.hiresult, model_hi);
            check_value({p, "loresult"}, res.loresult, model_lo);
            check_value({p, "result"}, res.result,
                        (ins.op == mips_pkg::OP_MFHI) ? model_hi : model_lo);
        end
        else
            check_value({p, "result"}, res.result, alu_expect(ins));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic mips_pkg::word_t random_operand();
        case (rand_below(8))
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            4:       return mips_pkg::word_t'(rand_below(16));
            5:       return 32'hffff_ffff >> rand_below(32);      // Leading zeros.
            6:       return ~(32'hffff_ffff >> rand_below(32));   // Leading ones.
            default: return $random(seed);
        endcase
    endfunction

    function automatic mips_pkg::issue_data_t random_issue(input logic hilo_only);
        mips_pkg::issue_data_t ins;
        logic [31:0]           r;
        int                    kind;
        ins  = '0;
        kind = rand_below(16);
        r    = $random(seed);
        if (kind == 0 && !hilo_only)
            return ins;                                 // Bubble.
        ins.valid = 1'b1;
        if (hilo_only || kind < 5)
            ins.op = mips_pkg::op_t'(6'(int'(mips_pkg::OP_MULT) + rand_below(10)));
        else
            ins.op = mips_pkg::op_t'(6'(rand_below(int'(mips_pkg::OP_JAL) + 1)));
        ins.srca    = random_operand();
        ins.srcb    = (rand_below(4) == 0) ? ins.srca : random_operand();
        ins.imm     = r[16] ? {{16{r[15]}}, r[15:0]} : {16'b0, r[15:0]};
        ins.use_imm = (ins.op == mips_pkg::OP_LUI) ||
                      ((ins.op inside {[mips_pkg::OP_ADD:mips_pkg::OP_SLTU]}) && r[17]);
        ins.shamt   = r[22:18];
        ins.destreg = r[27:23];
        ins.pcplus4 = $random(seed) & 32'hffff_fffc;
        return ins;
    endfunction

    function automatic mips_pkg::issue_data_t directed_issue(input mips_pkg::op_t op,
                                                              input mips_pkg::word_t a,
                                                              input mips_pkg::word_t b);
        mips_pkg::issue_data_t ins;
        ins         = '0;
        ins.valid   = 1'b1;
        ins.op      = op;
        ins.srca    = a;
        ins.srcb    = b;
        ins.destreg = 5'd2;
        return ins;
    endfunction

    // One operation on lane 0, held until finish.
    task automatic run_single(input mips_pkg::issue_data_t ins);
        int waited;
        waited = 0;
        @(posedge clk);
        in0 <= ins;
        @(negedge clk);
        while (!finish0)
        begin
            waited++;
            if (waited > TIMEOUT_CYCLES)
                abort_run("lane 0 never finished a directed operation");
            @(negedge clk);
        end
        check_result(0, ins, out0);
        @(posedge clk);
        in0 <= '0;
    endtask

    task automatic run_lanes(input int count, input logic hilo_only);
        mips_pkg::issue_data_t cur    [2];
        mips_pkg::exec_data_t  res    [2];
        logic                  fin    [2];
        int                    left   [2];
        int                    waited [2];
        for (int i = 0; i < 2; i++)
        begin
            cur[i]    = random_issue(hilo_only);
            left[i]   = count;
            waited[i] = 0;
        end
        while (left[0] > 0 || left[1] > 0)
        begin
            @(posedge clk);
            in0 <= cur[0];
            in1 <= cur[1];
            @(negedge clk);
            res[0] = out0;
            res[1] = out1;
            fin[0] = finish0;
            fin[1] = finish1;
            for (int i = 0; i < 2; i++)
            begin
                if (left[i] == 0)
                    continue;
                if (!cur[i].valid)
                    check_value($sformatf("out%0d.valid", i), res[i].valid, 1'b0);
                if (!cur[i].valid || !is_hilo(cur[i].op))
                    check_value($sformatf("finish%0d", i), fin[i], 1'b1);
                else if (!fin[i])
                begin
                    waited[i]++;
                    if (waited[i] > TIMEOUT_CYCLES)
                        abort_run($sformatf("lane %0d waited too long for the shared unit", i));
                    continue;
                end
                if (cur[i].valid)
                    check_result(i, cur[i], res[i]);
                waited[i] = 0;
                left[i]--;
                if (left[i] > 0)
                    cur[i] = random_issue(hilo_only);
                else
                    cur[i] = '0;
            end
        end
        @(posedge clk);
        in0 <= '0;
        in1 <= '0;
    endtask

    task automatic flush_during_divide();
        run_single(directed_issue(mips_pkg::OP_MULT, $random(seed), $random(seed)));
        @(posedge clk);
        in0 <= directed_issue(mips_pkg::OP_DIV, 32'h1234_5678, 32'd7);
        for (int c = 0; c < 8; c++)
        begin
            @(negedge clk);
            if (finish0)
                abort_run("the divide finished although a flush was still to come");
        end
        @(posedge clk);
        flush <= 1'b1;
        in0   <= '0;
        @(posedge clk);
        flush <= 1'b0;
        run_single(directed_issue(mips_pkg::OP_MFHI, '0, '0));   // Multiply result kept.
        run_single(directed_issue(mips_pkg::OP_MFLO, '0, '0));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        seed     = 32'hd5ae_3a25;
        model_hi = '0;
        model_lo = '0;
        reset    = 1'b1;
        flush    = 1'b0;
        in0      = '0;
        in1      = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        run_single(directed_issue(mips_pkg::OP_MFHI, '0, '0));   // HI is zero after reset.
        run_single(directed_issue(mips_pkg::OP_DIV, 32'd7, 32'd0));
        run_single(directed_issue(mips_pkg::OP_MFHI, '0, '0));
        run_single(directed_issue(mips_pkg::OP_DIVU, 32'hffff_fff0, 32'd0));
        run_single(directed_issue(mips_pkg::OP_MFLO, '0, '0));
        run_single(directed_issue(mips_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff));
        run_single(directed_issue(mips_pkg::OP_DIV, 32'hffff_fff9, 32'd2));

        run_lanes(400, 1'b0);
        run_lanes(60, 1'b1);                            // Both lanes contend every cycle.
        flush_during_divide();

        $display("Verification passed");
        $finish;
    end

endmodule
